// ==== files.f ====
+incdir+hdl
hdl/opcodes.sv
hdl/isa.sv
hdl/regBlock.sv
hdl/alu.sv
hdl/datapath.sv
hdl/control.sv
hdl/cpu.sv
sim/cpu_assert.sv
sim/cpu_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"
`default_nettype none

module alu (
	input  wire  [`DATA_W-1:0]  op1,
	input  wire  [`DATA_W-1:0]  op2,
	input  opcodes::aluOpT      aluOp,
	output logic [`DATA_W-1:0]  result,
	output logic [3:0]          flags
);

	import opcodes::*;

	logic               isSub;
	logic [`DATA_W-1:0] opB;    // second addend before inversion
	logic [`DATA_W-1:0] bEff;
	logic [`DATA_W:0]   sum;    // carry in top bit
	logic               arith;
	logic               carry, ovf;

	// inc and dec reuse the adder with a constant one
	assign isSub = (aluOp == AluSub) || (aluOp == AluDec);
	assign opB   = (aluOp == AluInc || aluOp == AluDec) ? `DATA_W'(1) : op2;
	assign bEff  = isSub ? ~opB : opB;
	assign sum   = {1'b0, op1} + {1'b0, bEff} + {{`DATA_W{1'b0}}, isSub};

	assign arith = (aluOp == AluAdd) || (aluOp == AluSub) ||
	               (aluOp == AluInc) || (aluOp == AluDec);

	always_comb begin
		case (aluOp)
			AluAnd:   result = op1 & op2;
			AluOr:    result = op1 | op2;
			AluXor:   result = op1 ^ op2;
			AluPass2: result = op2;
			default:  result = sum[`DATA_W-1:0];
		endcase
	end

	// carry is not-borrow on subtract
	assign carry = arith & sum[`DATA_W];
	// signs of the addends agree but the sum's sign differs
	assign ovf   = arith & (op1[`DATA_W-1] == bEff[`DATA_W-1]) &
	               (sum[`DATA_W-1] != op1[`DATA_W-1]);

	always_comb begin
		flags          = '0;
		flags[`FLAG_N] = result[`DATA_W-1];
		flags[`FLAG_Z] = (result == '0);
		flags[`FLAG_C] = carry;
		flags[`FLAG_V] = ovf;
	end

endmodule

`default_nettype wire

// ==== hdl/control.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"
`default_nettype none

module control (
	input  wire              Clock,
	input  wire              rstN,
	input  isa::instrT       instr,
	input  wire  [3:0]       flags,
	output opcodes::pcSelT   pcSel,
	output opcodes::op1SelT  op1Sel,
	output opcodes::busSelT  busSel,
	output opcodes::adrSelT  adrSel,
	output opcodes::aluOpT   aluOp,
	output logic             pcWe,
	output logic             lrWe,
	output logic             spWe,
	output logic             irWe,
	output logic             aluWe,
	output logic             flagWe,
	output logic             regWe,
	output logic             op2Sel,
	output logic             wdSel,
	output logic             memWe,
	output logic             halted
);

	import opcodes::*;
	import isa::*;

	ctrlStateT state, nextState;
	aluOpT     rrOp;  // alu op for register-register forms

	always_ff @(posedge Clock) begin
		if (!rstN)
			state <= SFetch;
		else
			state <= nextState;
	end

	always_comb begin
		case (instr)
			OpSub:   rrOp = AluSub;
			OpAnd:   rrOp = AluAnd;
			OpOr:    rrOp = AluOr;
			OpXor:   rrOp = AluXor;
			default: rrOp = AluAdd;
		endcase
	end

	assign halted = (state == SHalt);

	always_comb begin
		pcSel     = PcInc;
		op1Sel    = Op1Rd1;
		busSel    = BusAlu;
		adrSel    = AdrPc;
		aluOp     = AluAdd;
		op2Sel    = 1'b0;
		wdSel     = 1'b0;
		{pcWe, lrWe, spWe, irWe, aluWe, flagWe, regWe, memWe} = '0;
		nextState = state;
		case (state)
			SFetch: begin
				busSel    = BusMem;
				irWe      = 1'b1;
				pcWe      = 1'b1;
				nextState = SDecode;
			end
			SDecode: begin
				// aluOut gets the branch target, or rs1 + imm for memory ops
				aluWe     = 1'b1;
				op1Sel    = (instr == OpLd || instr == OpSt) ? Op1Rd1 : Op1Pc;
				nextState = (instr == OpHalt) ? SHalt : SExec;
			end
			SExec: begin
				nextState = SFetch;
				case (instr)
					OpAdd, OpSub, OpAnd, OpOr, OpXor: begin
						aluOp  = rrOp;
						op2Sel = 1'b1;
						flagWe = 1'b1;
						regWe  = 1'b1;
					end
					OpAddi: begin
						flagWe = 1'b1;
						regWe  = 1'b1;
					end
					OpLd: nextState = SMem;
					OpSt: begin
						adrSel = AdrAlu;
						memWe  = 1'b1;
					end
					OpBz: begin
						pcSel = PcAluOut;
						pcWe  = flags[`FLAG_Z];  // only taken on zero
					end
					OpJal: begin
						lrWe  = 1'b1;
						pcSel = PcAluOut;
						pcWe  = 1'b1;
					end
					OpRet: begin
						pcSel = PcLr;
						pcWe  = 1'b1;
					end
					OpPush: begin
						adrSel = AdrSp;   // write at sp, then step down
						memWe  = 1'b1;
						op1Sel = Op1Sp;
						aluOp  = AluDec;
						spWe   = 1'b1;
					end
					OpPop: begin
						op1Sel    = Op1Sp;
						aluOp     = AluInc;
						spWe      = 1'b1;
						nextState = SMem;
					end
					default: ;  // nop
				endcase
			end
			SMem: begin
				busSel    = BusMem;
				adrSel    = (instr == OpPop) ? AdrSp : AdrAlu;
				wdSel     = 1'b1;
				regWe     = 1'b1;
				nextState = SFetch;
			end
			SHalt:   nextState = SHalt;
			default: nextState = SFetch;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/cpu.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"
`default_nettype none

module cpu (
	input  wire                 Clock,
	input  wire                 rstN,
	input  wire  [`DATA_W-1:0]  memRData,
	output logic [`DATA_W-1:0]  memAddr,
	output logic [`DATA_W-1:0]  memWData,
	output logic                memWe,
	output logic                halted,
	output logic [3:0]          flags
);

	import opcodes::*;
	import isa::*;

	pcSelT  pcSel;
	op1SelT op1Sel;
	busSelT busSel;
	adrSelT adrSel;
	aluOpT  aluOp;
	instrT  instr;
	logic   pcWe, lrWe, spWe, irWe, aluWe, flagWe, regWe;
	logic   op2Sel, wdSel;

	control ctrl (
		.Clock  (Clock  ), .rstN   (rstN   ),
		.instr  (instr  ), .flags  (flags  ),
		.pcSel  (pcSel  ), .op1Sel (op1Sel ), .busSel (busSel ),
		.adrSel (adrSel ), .aluOp  (aluOp  ),
		.pcWe   (pcWe   ), .lrWe   (lrWe   ), .spWe   (spWe   ), .irWe  (irWe  ),
		.aluWe  (aluWe  ), .flagWe (flagWe ), .regWe  (regWe  ),
		.op2Sel (op2Sel ), .wdSel  (wdSel  ),
		.memWe  (memWe  ), .halted (halted )
	);

	datapath dp (
		.Clock    (Clock    ), .rstN     (rstN     ),
		.memRData (memRData ), .memAddr  (memAddr  ), .memWData (memWData ),
		.instr    (instr    ), .flags    (flags    ),
		.pcSel    (pcSel    ), .op1Sel   (op1Sel   ), .busSel   (busSel   ),
		.adrSel   (adrSel   ), .aluOp    (aluOp    ),
		.pcWe     (pcWe     ), .lrWe     (lrWe     ), .spWe     (spWe     ),
		.irWe     (irWe     ), .aluWe    (aluWe    ), .flagWe   (flagWe   ),
		.regWe    (regWe    ), .op2Sel   (op2Sel   ), .wdSel    (wdSel    )
	);

endmodule

`default_nettype wire

// ==== hdl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and address width
`define DATA_W 16

// register file geometry
`define REG_CNT 8
`define REG_IDX_W 3

// stack grows down from here
`define SP_RESET 16'h00FF

// bit positions in the flags word
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0

`endif

// ==== hdl/datapath.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"
`default_nettype none

module datapath (
	input  wire                 Clock,
	input  wire                 rstN,
	input  wire  [`DATA_W-1:0]  memRData,
	output logic [`DATA_W-1:0]  memAddr,
	output logic [`DATA_W-1:0]  memWData,
	output isa::instrT          instr,
	output logic [3:0]          flags,
	input  opcodes::pcSelT      pcSel,
	input  opcodes::op1SelT     op1Sel,
	input  opcodes::busSelT     busSel,
	input  opcodes::adrSelT     adrSel,
	input  opcodes::aluOpT      aluOp,
	input  wire                 pcWe,
	input  wire                 lrWe,
	input  wire                 spWe,
	input  wire                 irWe,
	input  wire                 aluWe,
	input  wire                 flagWe,
	input  wire                 regWe,
	input  wire                 op2Sel,  // 1 picks rd2, 0 the immediate
	input  wire                 wdSel    // 1 picks the bus, 0 the alu result
);

	import opcodes::*;
	import isa::*;

	logic [`DATA_W-1:0] pc, lr, sp, ir, aluOut;
	logic [`DATA_W-1:0] pcNext, bus, immExt;
	logic [`DATA_W-1:0] op1, op2, aluRes, wData;
	logic [`DATA_W-1:0] rd1, rd2;
	logic [3:0]         aluFlags;

	assign immExt = {{(`DATA_W-5){ir[10]}}, ir[10:6]};
	assign instr  = instrT'(ir[15:11]);
	assign op2    = op2Sel ? rd2 : immExt;
	assign wData  = wdSel ? bus : aluRes;

	always_comb begin
		case (busSel)
			BusPc:   bus = pc;
			BusLr:   bus = lr;
			BusSp:   bus = sp;
			BusAlu:  bus = aluOut;
			default: bus = memRData;
		endcase
	end

	always_comb begin
		case (op1Sel)
			Op1Pc:   op1 = pc;
			Op1Sp:   op1 = sp;
			default: op1 = rd1;
		endcase
	end

	always_comb begin
		case (pcSel)
			PcLr:     pcNext = lr;
			PcAluOut: pcNext = aluOut;
			PcBus:    pcNext = bus;
			default:  pcNext = pc + 1'b1;
		endcase
	end

	always_comb begin
		case (adrSel)
			AdrAlu:  memAddr = aluOut;
			AdrSp:   memAddr = sp;
			default: memAddr = pc;
		endcase
	end

	assign memWData = rd2;

	regBlock regs (
		.Clock (Clock   ),
		.rstN  (rstN    ),
		.we    (regWe   ),
		.rs1   (ir[5:3] ),
		.rs2   (ir[8:6] ),
		.rw    (ir[2:0] ),
		.wData (wData   ),
		.rd1   (rd1     ),
		.rd2   (rd2     )
	);

	alu alu (
		.op1    (op1      ),
		.op2    (op2      ),
		.aluOp  (aluOp    ),
		.result (aluRes   ),
		.flags  (aluFlags )
	);

	// architectural state
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc    <= '0;
			lr    <= '0;
			sp    <= `SP_RESET;
			flags <= '0;
		end else begin
			if (pcWe)   pc    <= pcNext;
			if (lrWe)   lr    <= pc;       // return address is the already incremented pc
			if (spWe)   sp    <= aluRes;
			if (flagWe) flags <= aluFlags;
		end
	end

	always_ff @(posedge Clock) begin
		if (irWe)  ir     <= bus;
		if (aluWe) aluOut <= aluRes;
	end

endmodule

`default_nettype wire

// ==== hdl/isa.sv ====
`default_nettype none

package isa;

	// instruction bits 15:11, any other code is a nop
	typedef enum logic [4:0] {
		OpAdd  = 5'h01,
		OpSub  = 5'h02,
		OpAnd  = 5'h03,
		OpOr   = 5'h04,
		OpXor  = 5'h05,
		OpAddi = 5'h06,
		OpLd   = 5'h08,
		OpSt   = 5'h09,  // stores rs2, which shares bits 8:6 with the immediate
		OpBz   = 5'h0A,
		OpJal  = 5'h0B,
		OpRet  = 5'h0C,
		OpPush = 5'h0D,
		OpPop  = 5'h0E,
		OpHalt = 5'h1F
	} instrT;

	typedef enum logic [2:0] {
		SFetch,
		SDecode,
		SExec,
		SMem,
		SWrite,
		SHalt
	} ctrlStateT;

endpackage

`default_nettype wire

// ==== hdl/opcodes.sv ====
`default_nettype none

package opcodes;

	// next pc source
	typedef enum logic [1:0] {
		PcLr,
		PcAluOut,
		PcBus,
		PcInc
	} pcSelT;

	// first alu operand
	typedef enum logic [1:0] {
		Op1Rd1,
		Op1Pc,
		Op1Sp
	} op1SelT;

	// one value per source driving the internal bus
	typedef enum logic [2:0] {
		BusMem,
		BusPc,
		BusLr,
		BusSp,
		BusAlu
	} busSelT;

	typedef enum logic [1:0] {
		AdrPc,
		AdrAlu,
		AdrSp
	} adrSelT;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluPass2,
		AluInc,  // op1 + 1
		AluDec   // op1 - 1
	} aluOpT;

endpackage

`default_nettype wire

// ==== hdl/regBlock.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"
`default_nettype none

module regBlock (
	input  wire                    Clock,
	input  wire                    rstN,
	input  wire                    we,
	input  wire  [`REG_IDX_W-1:0]  rs1,
	input  wire  [`REG_IDX_W-1:0]  rs2,
	input  wire  [`REG_IDX_W-1:0]  rw,
	input  wire  [`DATA_W-1:0]     wData,
	output logic [`DATA_W-1:0]     rd1,
	output logic [`DATA_W-1:0]     rd2
);

	logic [`DATA_W-1:0] regs [`REG_CNT];

	// r0 is an ordinary register here
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];  // also the store data

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the cpu testbench with Verilator and run it into a log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f files.f -o cpu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== sim/cpu_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_assert (
	input wire Clock,
	input wire rstN,
	input wire memWe,
	input wire halted
);

	int failCount = 0;  // read by the testbench at the end

	// a store is a one-cycle strobe
	property singleStrobe;
		@(posedge Clock) disable iff (!rstN) memWe |=> !memWe;
	endproperty

	// only reset leaves the halt state
	property haltSticks;
		@(posedge Clock) (halted && rstN) |=> halted;
	endproperty

	property quietAfterReset;
		@(posedge Clock) !rstN |=> (!memWe && !halted);
	endproperty

	strobeCheck: assert property (singleStrobe) else begin
		$error("memWe high in two consecutive cycles");
		failCount++;
	end

	haltCheck: assert property (haltSticks) else begin
		$error("halted fell without reset");
		failCount++;
	end

	resetCheck: assert property (quietAfterReset) else begin
		$error("memWe or halted high right after reset");
		failCount++;
	end

endmodule

bind cpu cpu_assert chk (
	.Clock  (Clock  ),
	.rstN   (rstN   ),
	.memWe  (memWe  ),
	.halted (halted )
);

`default_nettype wire

// ==== sim/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"
`default_nettype none

module cpu_tb;

	import isa::*;

	// executed instructions, idle cycles after halt, reset pulses of 6 cycles
	localparam int InstrCnt  = 53;
	localparam int IdleCnt   = 28;
	localparam int ResetCnt  = 8 * 6;
	localparam int CycleLim  = 2 * (4 * InstrCnt + IdleCnt + ResetCnt);

	logic               Clock = 1'b0;
	logic               rstN = 1'b0;
	logic [`DATA_W-1:0] memRData;
	logic [`DATA_W-1:0] memAddr, memWData;
	logic               memWe, halted;
	logic [3:0]         flags;

	logic [`DATA_W-1:0] mem [256];
	logic [`DATA_W-1:0] expAddr [$];
	logic [`DATA_W-1:0] expData [$];
	int storeIdx = 0;
	int errors = 0;
	int testErrStart = 0;  // error count when the current test began
	int passCnt = 0;
	int failCnt = 0;
	int cycles = 0;
	int loadPtr = 0;

	cpu DUT (
		.Clock    (Clock    ),
		.rstN     (rstN     ),
		.memRData (memRData ),
		.memAddr  (memAddr  ),
		.memWData (memWData ),
		.memWe    (memWe    ),
		.halted   (halted   ),
		.flags    (flags    )
	);

	always #10 Clock = ~Clock;

	assign memRData = mem[memAddr[7:0]];  // combinational read

	always @(posedge Clock) begin
		cycles++;
		if (cycles >= CycleLim) begin
			$display("timeout: cpu did not halt within %0d cycles", CycleLim);
			$display("sim failed");
			$finish;
		end
	end

	// memory write plus check against the expected store table
	always @(posedge Clock) begin
		if (memWe === 1'b1) begin
			mem[memAddr[7:0]] <= memWData;
			if (rstN === 1'b1) begin
				if (storeIdx < expAddr.size()) begin
					assert (memAddr == expAddr[storeIdx]) else begin
						$display("ERR memAddr expected %h got %h", expAddr[storeIdx], memAddr);
						errors++;
					end
					assert (memWData == expData[storeIdx]) else begin
						$display("ERR memWData expected %h got %h", expData[storeIdx], memWData);
						errors++;
					end
				end else begin
					$display("unexpected store of %h at address %h", memWData, memAddr);
					errors++;
				end
				storeIdx++;
			end
		end
	end

	function automatic logic [15:0] encode(input instrT op, input int imm, input int rs1,
		input int rd);
		logic [4:0] imm5;
		logic [2:0] s1, d;
		imm5 = imm[4:0];
		s1   = rs1[2:0];
		d    = rd[2:0];
		return {op, imm5, s1, d};
	endfunction

	// r0 based store slots at 0xFFF0+k or 0xFFF8+k; imm bits 2:0 pick the stored register
	function automatic logic [15:0] storeInstr(input int k, input bit upper);
		return encode(OpSt, upper ? k - 8 : k - 16, 0, 0);
	endfunction

	function automatic logic [15:0] slotAddr(input int k, input bit upper);
		return 16'hFFF0 + 16'(k) + (upper ? 16'd8 : 16'd0);
	endfunction

	task automatic newProgram();
		for (int a = 0; a < 256; a++)
			mem[a] = {8'h00, 8'(a)};  // opcode 0 is a nop
		expAddr.delete();
		expData.delete();
		storeIdx     = 0;
		loadPtr      = 0;
		testErrStart = errors;
	endtask

	task automatic emit(input logic [15:0] word);
		mem[loadPtr] = word;
		loadPtr++;
	endtask

	task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic resetPulse();
		@(posedge Clock);
		rstN <= 1'b0;
		repeat (5) @(posedge Clock);
		rstN <= 1'b1;
		@(negedge Clock);
		assert (memAddr == 16'h0000) else begin
			$display("ERR memAddr expected %h got %h", 16'h0000, memAddr);
			errors++;
		end
		assert (memWe == 1'b0) else begin
			$display("ERR memWe expected %h got %h", 1'b0, memWe);
			errors++;
		end
	endtask

	task automatic finishTest(input int num, input string name, input logic [3:0] mask,
		input logic [3:0] expFlags);
		while (halted !== 1'b1)
			@(posedge Clock);
		repeat (4) @(posedge Clock);  // stores after halt would show up here
		@(negedge Clock);
		if (mask != 4'h0) begin
			assert ((flags & mask) == expFlags) else begin
				$display("ERR flags expected %h got %h", expFlags, flags & mask);
				errors++;
			end
		end
		assert (storeIdx == expAddr.size()) else begin
			$display("only %0d of %0d expected stores happened", storeIdx, expAddr.size());
			errors++;
		end
		if (errors == testErrStart && storeIdx == expAddr.size()) begin
			passCnt++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failCnt++;
			$display("test %0d %s: FAILED", num, name);
		end
	endtask

	initial begin
		logic [15:0] a, b;
		a = 16'd9;
		b = 16'hFFFD;  // -3

		newProgram();
		emit(encode(OpAddi, 9, 0, 1));
		emit(encode(OpAddi, -3, 0, 2));
		emit(encode(OpAdd, 2, 1, 3));
		emit(encode(OpSub, 2, 1, 4));
		emit(encode(OpAnd, 2, 1, 5));
		emit(encode(OpOr, 2, 1, 6));
		emit(encode(OpXor, 2, 1, 7));
		for (int k = 3; k <= 7; k++)
			emit(storeInstr(k, 0));
		emit(encode(OpHalt, 0, 0, 0));
		expectStore(slotAddr(3, 0), a + b);
		expectStore(slotAddr(4, 0), a - b);
		expectStore(slotAddr(5, 0), a & b);
		expectStore(slotAddr(6, 0), a | b);
		expectStore(slotAddr(7, 0), a ^ b);
		resetPulse();
		finishTest(1, "alu ops", 4'h0, 4'h0);

		newProgram();
		emit(encode(OpAddi, 5, 0, 1));
		emit(encode(OpAddi, 5, 0, 2));
		emit(encode(OpSub, 2, 1, 3));  // equal operands
		emit(encode(OpHalt, 0, 0, 0));
		resetPulse();
		finishTest(2, "zero flag", 4'(1 << `FLAG_Z) | 4'(1 << `FLAG_N), 4'(1 << `FLAG_Z));

		newProgram();
		mem[8'hF0] = 16'h7FFF;
		emit(encode(OpLd, -16, 0, 1));
		emit(encode(OpAddi, 1, 0, 2));
		emit(encode(OpAdd, 2, 1, 3));
		emit(storeInstr(3, 1));
		emit(encode(OpHalt, 0, 0, 0));
		expectStore(slotAddr(3, 1), 16'h7FFF + 16'h0001);
		resetPulse();
		finishTest(3, "overflow flags", 4'hF,
			4'(1 << `FLAG_N) | 4'(1 << `FLAG_V));

		newProgram();
		emit(encode(OpAddi, 13, 0, 1));
		emit(storeInstr(1, 0));
		emit(encode(OpAddi, 1, 0, 2));
		emit(encode(OpLd, -16, 2, 3));  // r2 - 16 hits the first slot
		emit(storeInstr(3, 1));
		emit(encode(OpHalt, 0, 0, 0));
		expectStore(slotAddr(1, 0), 16'd13);
		expectStore(slotAddr(3, 1), 16'd13);
		resetPulse();
		finishTest(4, "load store", 4'h0, 4'h0);

		newProgram();
		emit(encode(OpAddi, 4, 0, 1));
		emit(encode(OpSub, 1, 1, 2));
		emit(encode(OpBz, 1, 0, 0));     // taken, skips the next store
		emit(storeInstr(1, 0));
		emit(encode(OpAddi, 7, 0, 3));
		emit(encode(OpBz, 1, 0, 0));     // not taken
		emit(storeInstr(3, 0));
		emit(encode(OpHalt, 0, 0, 0));
		expectStore(slotAddr(3, 0), 16'd7);
		resetPulse();
		finishTest(5, "branch", 4'h0, 4'h0);

		newProgram();
		emit(encode(OpAddi, 5, 0, 1));
		emit(encode(OpAddi, 6, 0, 2));
		emit(encode(OpJal, 3, 0, 0));    // routine at 6
		emit(storeInstr(4, 0));          // return lands here
		emit(storeInstr(5, 0));
		emit(encode(OpHalt, 0, 0, 0));
		emit(encode(OpPush, 1, 0, 0));
		emit(encode(OpPush, 2, 0, 0));
		emit(encode(OpPop, 0, 0, 4));
		emit(encode(OpPop, 0, 0, 5));
		emit(encode(OpRet, 0, 0, 0));
		expectStore(`SP_RESET, 16'd5);
		expectStore(`SP_RESET - 16'd1, 16'd6);
		expectStore(slotAddr(4, 0), 16'd6);
		expectStore(slotAddr(5, 0), 16'd5);
		resetPulse();
		finishTest(6, "subroutine stack", 4'h0, 4'h0);

		newProgram();
		emit(encode(OpAddi, 1, 0, 1));
		emit(storeInstr(1, 0));
		emit(encode(OpAddi, 1, 1, 1));
		emit(storeInstr(1, 1));
		emit(encode(OpHalt, 0, 0, 0));
		emit(storeInstr(2, 0));          // past halt, never reached
		// first store, then the restart repeats it with r1 cleared
		expectStore(slotAddr(1, 0), 16'd1);
		expectStore(slotAddr(1, 0), 16'd1);
		expectStore(slotAddr(1, 1), 16'd2);
		resetPulse();
		wait (storeIdx == 1);
		resetPulse();
		finishTest(7, "reset and halt", 4'h0, 4'h0);

		$display("tests passed %0d failed %0d", passCnt, failCnt);
		if (failCnt == 0 && errors == 0 && DUT.chk.failCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
